//--- rtl/dcache_pkg.sv
package dcache_pkg;

    // Cache geometry.
    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;
    localparam int TAG_W    = 21;
    localparam int INDEX_W  = 7;
    localparam int OFFSET_W = 4;
    localparam int LINES    = 128;
    localparam int LINE_W   = 128; // Data bits of one line.
    localparam int BEATS    = 4;   // Bus words per line.
    localparam int BEAT_W   = 2;

    // RV32 funct3 codes for loads and stores.
    localparam int FUNCT_W = 3;

    localparam logic [FUNCT_W-1:0] OP_LB  = 3'b000;
    localparam logic [FUNCT_W-1:0] OP_LH  = 3'b001;
    localparam logic [FUNCT_W-1:0] OP_LW  = 3'b010;
    localparam logic [FUNCT_W-1:0] OP_LBU = 3'b100;
    localparam logic [FUNCT_W-1:0] OP_LHU = 3'b101;
    localparam logic [FUNCT_W-1:0] OP_SB  = 3'b000;
    localparam logic [FUNCT_W-1:0] OP_SH  = 3'b001;
    localparam logic [FUNCT_W-1:0] OP_SW  = 3'b010;

    // Controller state codes.
    localparam int ST_W = 2;

    localparam logic [ST_W-1:0] ST_IDLE      = 2'd0;
    localparam logic [ST_W-1:0] ST_LOOKUP    = 2'd1;
    localparam logic [ST_W-1:0] ST_WRITEBACK = 2'd2;
    localparam logic [ST_W-1:0] ST_REFILL    = 2'd3;

    // One address word, seen whole or split into its cache fields.
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } f;
    } cache_addr_u;

endpackage

//--- rtl/dcache_ctrl.sv
module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,

    input  logic                 req_i,
    input  logic                 we_i,
    input  cache_addr_u          addr_i,

    input  logic [TAG_W-1:0]     ram_tag_i,
    input  logic                 ram_valid_i,
    input  logic                 ram_dirty_i,
    input  logic [LINE_W-1:0]    ram_line_i,
    input  logic [LINE_W-1:0]    merge_line_i,

    input  logic                 bus_done_i,
    input  logic [LINE_W-1:0]    bus_line_i,

    output logic                 ram_en_o,
    output logic                 ram_we_o,
    output logic [INDEX_W-1:0]   ram_index_o,
    output logic [TAG_W-1:0]     ram_tag_o,
    output logic [LINE_W-1:0]    ram_line_o,
    output logic                 ram_dirty_o,

    output logic                 bus_start_o,
    output logic                 bus_we_o,
    output cache_addr_u          bus_adr_o,
    output logic [LINE_W-1:0]    bus_line_o,

    output logic                 sel_fetched_o,
    output logic                 ack_o
);

    logic [ST_W-1:0] state_q;
    logic [ST_W-1:0] state_d;

    logic        hit;
    cache_addr_u refill_adr;
    cache_addr_u victim_adr;

    assign hit = ram_valid_i && (ram_tag_i == addr_i.f.tag);

    always_comb begin
        refill_adr.f.tag    = addr_i.f.tag;
        refill_adr.f.index  = addr_i.f.index;
        refill_adr.f.offset = '0;

        // The evicted line lives at the stored tag and the same index.
        victim_adr.f.tag    = ram_tag_i;
        victim_adr.f.index  = addr_i.f.index;
        victim_adr.f.offset = '0;
    end

    assign ram_index_o   = addr_i.f.index; // Address is held for the whole request.
    assign ram_tag_o     = addr_i.f.tag;
    assign bus_line_o    = ram_line_i;     // Victim data, sampled by the master on start.
    assign sel_fetched_o = (state_q == ST_REFILL);

    always_comb begin
        state_d     = state_q;
        ram_en_o    = 1'b0;
        ram_we_o    = 1'b0;
        ram_line_o  = merge_line_i;
        ram_dirty_o = 1'b1;
        bus_start_o = 1'b0;
        bus_we_o    = 1'b0;
        bus_adr_o   = refill_adr;
        ack_o       = 1'b0;

        case (state_q)
            ST_IDLE: begin
                if (req_i) begin
                    ram_en_o = 1'b1; // Read tag and data.
                    state_d  = ST_LOOKUP;
                end
            end

            ST_LOOKUP: begin
                if (hit) begin
                    ack_o = 1'b1;
                    if (we_i) begin
                        ram_en_o = 1'b1;
                        ram_we_o = 1'b1;
                    end
                    state_d = ST_IDLE;
                end else if (ram_valid_i && ram_dirty_i) begin
                    bus_start_o = 1'b1;
                    bus_we_o    = 1'b1;
                    bus_adr_o   = victim_adr;
                    state_d     = ST_WRITEBACK;
                end else begin
                    bus_start_o = 1'b1;
                    state_d     = ST_REFILL;
                end
            end

            ST_WRITEBACK: begin
                // The bus cycle has already closed when done arrives.
                if (bus_done_i) begin
                    bus_start_o = 1'b1;
                    state_d     = ST_REFILL;
                end
            end

            ST_REFILL: begin
                if (bus_done_i) begin
                    ram_en_o    = 1'b1;
                    ram_we_o    = 1'b1;
                    ram_line_o  = we_i ? merge_line_i : bus_line_i;
                    ram_dirty_o = we_i;
                    ack_o       = 1'b1;
                    state_d     = ST_IDLE;
                end
            end

            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- rtl/dcache_line_ram.sv
module dcache_line_ram
    import dcache_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 en_i,
    input  logic                 we_i,
    input  logic [INDEX_W-1:0]   index_i,
    input  logic [TAG_W-1:0]     tag_i,
    input  logic [LINE_W-1:0]    line_i,
    input  logic                 dirty_i,
    output logic [TAG_W-1:0]     tag_o,
    output logic [LINE_W-1:0]    line_o,
    output logic                 valid_o,
    output logic                 dirty_o
);

    logic [TAG_W-1:0]  tag_mem  [LINES];
    logic [LINE_W-1:0] data_mem [LINES];

    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;

    // Read data stays put until the next read.
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                tag_mem[index_i]  <= tag_i;
                data_mem[index_i] <= line_i;
            end else begin
                tag_o  <= tag_mem[index_i];
                line_o <= data_mem[index_i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (en_i && we_i) begin
            valid_q[index_i] <= 1'b1;
            dirty_q[index_i] <= dirty_i;
        end
    end

    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];

endmodule

//--- rtl/dcache_load_align.sv
module dcache_load_align
    import dcache_pkg::*;
(
    input  logic [LINE_W-1:0]    line_i,
    input  logic [OFFSET_W-1:0]  offset_i,
    input  logic [FUNCT_W-1:0]   funct_i,
    output logic [WORD_W-1:0]    rdata_o
);

    logic [LINE_W-1:0] shifted;
    logic [WORD_W-1:0] word;

    // Bring the addressed byte down to bit 0.
    assign shifted = line_i >> {offset_i, 3'b000};
    assign word    = shifted[WORD_W-1:0];

    always_comb begin
        case (funct_i)
            OP_LB:   rdata_o = {{24{word[7]}}, word[7:0]};
            OP_LH:   rdata_o = {{16{word[15]}}, word[15:0]};
            OP_LBU:  rdata_o = {24'd0, word[7:0]};
            OP_LHU:  rdata_o = {16'd0, word[15:0]};
            default: rdata_o = word; // LW.
        endcase
    end

endmodule

//--- rtl/dcache_store_merge.sv
module dcache_store_merge
    import dcache_pkg::*;
(
    input  logic [LINE_W-1:0]    line_i,
    input  logic [OFFSET_W-1:0]  offset_i,
    input  logic [FUNCT_W-1:0]   funct_i,
    input  logic [WORD_W-1:0]    wdata_i,
    output logic [LINE_W-1:0]    line_o
);

    logic [LINE_W-1:0] mask;
    logic [LINE_W-1:0] data;

    always_comb begin
        case (funct_i)
            OP_SB:   mask = LINE_W'(32'h0000_00ff);
            OP_SH:   mask = LINE_W'(32'h0000_ffff);
            OP_SW:   mask = LINE_W'(32'hffff_ffff);
            default: mask = '0; // Not a store width, line unchanged.
        endcase
    end

    assign data   = LINE_W'(wdata_i) & mask;
    assign line_o = (line_i & ~(mask << {offset_i, 3'b000}))
                  | (data << {offset_i, 3'b000});

endmodule

//--- rtl/dcache_wb_master.sv
module dcache_wb_master
    import dcache_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 start_i,
    input  logic                 we_i,
    input  cache_addr_u          adr_i,
    input  logic [LINE_W-1:0]    line_i,
    input  logic [WORD_W-1:0]    wb_dat_i,
    input  logic                 wb_ack_i,
    output logic                 done_o,
    output logic [LINE_W-1:0]    line_o,
    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output logic                 wb_we_o,
    output logic [ADDR_W-1:0]    wb_adr_o,
    output logic [WORD_W-1:0]    wb_dat_o
);

    logic              cyc_q;
    logic              stb_q;
    logic              we_q;
    logic              done_q;
    logic [BEAT_W-1:0] cnt_q;
    logic [ADDR_W-1:0] adr_q;
    logic [LINE_W-1:0] shift_q;

    logic beat_ack;
    logic last_ack;

    assign beat_ack = stb_q && wb_ack_i;
    assign last_ack = beat_ack && (cnt_q == BEAT_W'(BEATS - 1));

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cyc_q  <= 1'b0;
            stb_q  <= 1'b0;
            we_q   <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= last_ack;
            if (!cyc_q) begin
                if (start_i) begin
                    cyc_q <= 1'b1;
                    stb_q <= 1'b1;
                    we_q  <= we_i;
                    cnt_q <= '0;
                end
            end else if (stb_q) begin
                if (wb_ack_i) begin
                    stb_q <= 1'b0;
                    cnt_q <= cnt_q + 1'b1;
                    if (last_ack) begin
                        cyc_q <= 1'b0;
                        we_q  <= 1'b0;
                    end
                end
            end else begin
                stb_q <= 1'b1; // One idle cycle between beats.
            end
        end
    end

    // Write words leave from the bottom, read words enter at the top.
    always_ff @(posedge clk_i) begin
        if (!cyc_q && start_i) begin
            adr_q   <= {adr_i.f.tag, adr_i.f.index, {OFFSET_W{1'b0}}};
            shift_q <= line_i;
        end else if (beat_ack) begin
            adr_q   <= adr_q + ADDR_W'(4);
            shift_q <= {wb_dat_i, shift_q[LINE_W-1:WORD_W]};
        end
    end

    assign done_o   = done_q;
    assign line_o   = shift_q;
    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = stb_q;
    assign wb_we_o  = we_q;
    assign wb_adr_o = adr_q;
    assign wb_dat_o = shift_q[WORD_W-1:0];

endmodule

//--- rtl/dcache_top.sv
module dcache_top
    import dcache_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,

    input  logic                 req_i,
    input  logic                 we_i,
    input  cache_addr_u          addr_i,
    input  logic [WORD_W-1:0]    wdata_i,
    input  logic [FUNCT_W-1:0]   funct_i,
    output logic [WORD_W-1:0]    rdata_o,
    output logic                 ack_o,

    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output logic                 wb_we_o,
    output logic [ADDR_W-1:0]    wb_adr_o,
    output logic [WORD_W-1:0]    wb_dat_o,
    input  logic [WORD_W-1:0]    wb_dat_i,
    input  logic                 wb_ack_i
);

    logic                ram_en;
    logic                ram_we;
    logic [INDEX_W-1:0]  ram_index;
    logic [TAG_W-1:0]    ram_wr_tag;
    logic [LINE_W-1:0]   ram_wr_line;
    logic                ram_wr_dirty;
    logic [TAG_W-1:0]    ram_rd_tag;
    logic [LINE_W-1:0]   ram_rd_line;
    logic                ram_valid;
    logic                ram_dirty;

    logic                bus_start;
    logic                bus_we;
    cache_addr_u         bus_adr;
    logic [LINE_W-1:0]   bus_wr_line;
    logic                bus_done;
    logic [LINE_W-1:0]   bus_rd_line;

    logic                sel_fetched;
    logic [LINE_W-1:0]   sel_line;
    logic [LINE_W-1:0]   merge_line;

    // Line seen by the aligner and merger.
    assign sel_line = sel_fetched ? bus_rd_line : ram_rd_line;

    dcache_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (req_i),
        .we_i          (we_i),
        .addr_i        (addr_i),
        .ram_tag_i     (ram_rd_tag),
        .ram_valid_i   (ram_valid),
        .ram_dirty_i   (ram_dirty),
        .ram_line_i    (ram_rd_line),
        .merge_line_i  (merge_line),
        .bus_done_i    (bus_done),
        .bus_line_i    (bus_rd_line),
        .ram_en_o      (ram_en),
        .ram_we_o      (ram_we),
        .ram_index_o   (ram_index),
        .ram_tag_o     (ram_wr_tag),
        .ram_line_o    (ram_wr_line),
        .ram_dirty_o   (ram_wr_dirty),
        .bus_start_o   (bus_start),
        .bus_we_o      (bus_we),
        .bus_adr_o     (bus_adr),
        .bus_line_o    (bus_wr_line),
        .sel_fetched_o (sel_fetched),
        .ack_o         (ack_o)
    );

    dcache_line_ram u_ram (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .index_i (ram_index),
        .tag_i   (ram_wr_tag),
        .line_i  (ram_wr_line),
        .dirty_i (ram_wr_dirty),
        .tag_o   (ram_rd_tag),
        .line_o  (ram_rd_line),
        .valid_o (ram_valid),
        .dirty_o (ram_dirty)
    );

    dcache_load_align u_align (
        .line_i   (sel_line),
        .offset_i (addr_i.f.offset),
        .funct_i  (funct_i),
        .rdata_o  (rdata_o)
    );

    dcache_store_merge u_merge (
        .line_i   (sel_line),
        .offset_i (addr_i.f.offset),
        .funct_i  (funct_i),
        .wdata_i  (wdata_i),
        .line_o   (merge_line)
    );

    dcache_wb_master u_wb (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (bus_start),
        .we_i     (bus_we),
        .adr_i    (bus_adr),
        .line_i   (bus_wr_line),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .done_o   (bus_done),
        .line_o   (bus_rd_line),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o)
    );

endmodule

//--- testbench/tb_mem_model.sv
module tb_mem_model (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [4096];  // 16 KiB window starting at address zero.
    logic [15:0] lfsr_q;
    logic [1:0]  wait_q;      // Cycles left before the open beat is acked.

    // Beat log, read by the testbench.
    logic [31:0] log_adr [1024];
    logic        log_we  [1024];
    logic [31:0] log_dat [1024];
    int          log_n;

    logic        cyc_q;
    logic        stb_q;
    int          cyc_n;       // Bus cycles opened.
    int          stb_n;       // Beats offered, one per rise of stb.

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 32'(i) ^ 32'h5A5A_0000; // Word address XOR a fixed pattern.
        end
    end

    assign ack_o = cyc_i && stb_i && (wait_q == 2'd0);
    assign dat_o = mem[adr_i[13:2]];

    always @(posedge clk_i) begin
        logic [15:0] s1;
        if (!rst_i) begin
            lfsr_q <= 16'd49432;
            wait_q <= 2'd0;
            log_n  <= 0;
        end else if (ack_o) begin
            if (we_i) begin
                mem[adr_i[13:2]] <= dat_i;
            end
            if (log_n < 1024) begin
                log_adr[log_n] <= adr_i;
                log_we[log_n]  <= we_i;
                log_dat[log_n] <= we_i ? dat_i : dat_o;
            end
            log_n <= log_n + 1;
            // Two bits give the wait of the next beat.
            s1     = lfsr_step(lfsr_q);
            wait_q <= {lfsr_q[0], s1[0]};
            lfsr_q <= lfsr_step(s1);
        end else if (cyc_i && stb_i) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    // Rising edges of cyc and stb.
    always @(posedge clk_i) begin
        if (!rst_i) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            cyc_n <= 0;
            stb_n <= 0;
        end else begin
            cyc_q <= cyc_i;
            stb_q <= stb_i;
            if (cyc_i && !cyc_q) begin
                cyc_n <= cyc_n + 1;
            end
            if (stb_i && !stb_q) begin
                stb_n <= stb_n + 1;
            end
        end
    end

endmodule

//--- testbench/tb_dcache.sv
module tb_dcache
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic               clk;
    logic               rst;
    logic               req;
    logic               we;
    cache_addr_u        addr;
    logic [WORD_W-1:0]  wdata;
    logic [FUNCT_W-1:0] funct;
    logic [WORD_W-1:0]  rdata;
    logic               ack;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [ADDR_W-1:0]  wb_adr;
    logic [WORD_W-1:0]  wb_dat_w;
    logic [WORD_W-1:0]  wb_dat_r;
    logic               wb_ack;

    logic [7:0]  shadow [16384]; // Core view of memory, one byte per entry.
    logic [15:0] lfsr;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          last_lat;

    dcache_top u_dut (
        .clk_i    (clk),
        .rst_i    (rst),
        .req_i    (req),
        .we_i     (we),
        .addr_i   (addr),
        .wdata_i  (wdata),
        .funct_i  (funct),
        .rdata_o  (rdata),
        .ack_o    (ack),
        .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb),
        .wb_we_o  (wb_we),
        .wb_adr_o (wb_adr),
        .wb_dat_o (wb_dat_w),
        .wb_dat_i (wb_dat_r),
        .wb_ack_i (wb_ack)
    );

    tb_mem_model u_mem (
        .clk_i (clk),
        .rst_i (rst),
        .cyc_i (wb_cyc),
        .stb_i (wb_stb),
        .we_i  (wb_we),
        .adr_i (wb_adr),
        .dat_i (wb_dat_w),
        .dat_o (wb_dat_r),
        .ack_o (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    task automatic fill_shadow();
        logic [31:0] w;
        for (int b = 0; b < 16384; b++) begin
            w         = (32'(b) >> 2) ^ 32'h5A5A_0000;
            shadow[b] = w[8 * (b % 4) +: 8]; // Little-endian bytes.
        end
    endtask

    function automatic logic [WORD_W-1:0] shadow_word(input logic [31:0] a);
        int b;
        b = int'(a[13:0]);
        return {shadow[b + 3], shadow[b + 2], shadow[b + 1], shadow[b]};
    endfunction

    function automatic logic [WORD_W-1:0] expect_load(input logic [31:0] a,
                                                      input logic [FUNCT_W-1:0] f);
        logic [31:0] w;
        w = shadow_word(a);
        case (f)
            OP_LB:   return {{24{w[7]}}, w[7:0]};
            OP_LH:   return {{16{w[15]}}, w[15:0]};
            OP_LBU:  return {24'd0, w[7:0]};
            OP_LHU:  return {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic apply_store(input logic [31:0] a, input logic [FUNCT_W-1:0] f,
                               input logic [31:0] d);
        for (int i = 0; i < (1 << f[1:0]); i++) begin
            shadow[int'(a[13:0]) + i] = d[8 * i +: 8];
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input cache_addr_u got,
                              input cache_addr_u exp);
        if (got.raw !== exp.raw) begin
            $display("FAIL %s: got %h, expected %h", name, got.raw, exp.raw);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // One request, held until ack_o and released on the next falling edge.
    task automatic access(input logic w, input logic [31:0] a, input logic [FUNCT_W-1:0] f,
                          input logic [31:0] d, output logic [WORD_W-1:0] rd);
        int waited;
        @(negedge clk);
        req       = 1'b1;
        we        = w;
        addr.raw  = a;
        funct     = f;
        wdata     = d;
        waited    = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && waited < 200);
        if (!ack) begin
            $display("no ack_o for the request to address %h within %0d cycles", a, waited);
            errors++;
        end
        rd       = rdata;
        last_lat = waited;
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic load(input logic [31:0] a, input logic [FUNCT_W-1:0] f);
        logic [WORD_W-1:0] rd;
        access(1'b0, a, f, '0, rd);
        check_word($sformatf("rdata_o at %h", a), rd, expect_load(a, f));
    endtask

    task automatic store(input logic [31:0] a, input logic [FUNCT_W-1:0] f,
                         input logic [31:0] d);
        logic [WORD_W-1:0] rd;
        access(1'b1, a, f, d, rd);
        apply_store(a, f, d);
    endtask

    task automatic hit_timing(input int n0);
        check_count("ack_o latency", last_lat, 1);
        check_count("wb beats", u_mem.log_n - n0, 0);
    endtask

    // Each line move is its own Wishbone cycle, and stb drops between beats.
    task automatic check_bus_cycles(input int c0, input int s0, input int cycles);
        check_count("wb_cyc_o cycles", u_mem.cyc_n - c0, cycles);
        check_count("wb_stb_o beats", u_mem.stb_n - s0, cycles * BEATS);
    endtask

    task automatic load_hit(input logic [31:0] a, input logic [FUNCT_W-1:0] f);
        int n0;
        n0 = u_mem.log_n;
        load(a, f);
        hit_timing(n0);
    endtask

    task automatic store_hit(input logic [31:0] a, input logic [FUNCT_W-1:0] f,
                             input logic [31:0] d);
        int n0;
        n0 = u_mem.log_n;
        store(a, f, d);
        hit_timing(n0);
    endtask

    // Four logged beats from a line base. Write data must match the core view.
    task automatic inspect_beats(input int first, input logic w, input logic [31:0] base);
        cache_addr_u got;
        cache_addr_u exp;
        for (int j = 0; j < BEATS; j++) begin
            got.raw = u_mem.log_adr[first + j];
            exp.raw = base + 32'(4 * j);
            check_addr("wb_adr_o", got, exp);
            check_word("wb_we_o", 32'(u_mem.log_we[first + j]), 32'(w));
            if (w) begin
                check_word("wb_dat_o", u_mem.log_dat[first + j], shadow_word(exp.raw));
            end
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d checks failed", name, errors - err0);
        end
    endtask

    task automatic cold_miss();
        int err0;
        int n0;
        int c0;
        int s0;
        err0 = errors;
        // Core and bus outputs are idle out of reset.
        check_word("ack_o", 32'(ack), 32'd0);
        check_word("wb_cyc_o", 32'(wb_cyc), 32'd0);
        check_word("wb_stb_o", 32'(wb_stb), 32'd0);
        check_word("wb_we_o", 32'(wb_we), 32'd0);
        n0   = u_mem.log_n;
        c0   = u_mem.cyc_n;
        s0   = u_mem.stb_n;
        load(32'h0000_0234, OP_LW);
        check_count("wb beats", u_mem.log_n - n0, 4);
        check_bus_cycles(c0, s0, 1);
        inspect_beats(n0, 1'b0, 32'h0000_0230);
        report_test("cold miss", err0);
    endtask

    task automatic load_hits();
        int err0;
        err0 = errors;
        load_hit(32'h0000_0234, OP_LB);  // 0x8d, sign bit set.
        load_hit(32'h0000_0236, OP_LH);
        load_hit(32'h0000_0238, OP_LW);
        load_hit(32'h0000_0237, OP_LBU);
        load_hit(32'h0000_023a, OP_LHU);
        report_test("load hits", err0);
    endtask

    task automatic store_hits();
        int err0;
        err0 = errors;
        store_hit(32'h0000_0231, OP_SB, 32'h0000_00a5);
        store_hit(32'h0000_023e, OP_SH, 32'h0000_8001);
        store_hit(32'h0000_0238, OP_SW, 32'hdead_beef);
        load_hit(32'h0000_0231, OP_LBU);
        load_hit(32'h0000_0231, OP_LB);
        load_hit(32'h0000_023e, OP_LH);
        load_hit(32'h0000_023e, OP_LHU);
        load_hit(32'h0000_0238, OP_LW);
        load_hit(32'h0000_0230, OP_LW);
        report_test("store hits", err0);
    endtask

    task automatic dirty_eviction();
        int err0;
        int n0;
        int c0;
        int s0;
        err0 = errors;
        n0   = u_mem.log_n;
        c0   = u_mem.cyc_n;
        s0   = u_mem.stb_n;
        load(32'h0000_0a34, OP_LW); // Same index, tag 1.
        check_count("wb beats", u_mem.log_n - n0, 8);
        check_bus_cycles(c0, s0, 2);
        inspect_beats(n0, 1'b1, 32'h0000_0230);
        inspect_beats(n0 + 4, 1'b0, 32'h0000_0a30);
        n0 = u_mem.log_n;
        c0 = u_mem.cyc_n;
        s0 = u_mem.stb_n;
        load(32'h0000_0231, OP_LBU);
        check_count("wb beats", u_mem.log_n - n0, 4); // Victim was clean.
        check_bus_cycles(c0, s0, 1);
        inspect_beats(n0, 1'b0, 32'h0000_0230);
        load_hit(32'h0000_023e, OP_LH);
        load_hit(32'h0000_0238, OP_LW);
        report_test("dirty eviction", err0);
    endtask

    task automatic write_allocate();
        int err0;
        int n0;
        int c0;
        int s0;
        err0 = errors;
        n0   = u_mem.log_n;
        c0   = u_mem.cyc_n;
        s0   = u_mem.stb_n;
        store(32'h0000_1404, OP_SW, 32'h1234_5678);
        check_count("wb beats", u_mem.log_n - n0, 4);
        check_bus_cycles(c0, s0, 1);
        inspect_beats(n0, 1'b0, 32'h0000_1400);
        load_hit(32'h0000_1404, OP_LW);
        n0 = u_mem.log_n;
        c0 = u_mem.cyc_n;
        s0 = u_mem.stb_n;
        load(32'h0000_0404, OP_LW);
        check_count("wb beats", u_mem.log_n - n0, 8);
        check_bus_cycles(c0, s0, 2);
        inspect_beats(n0, 1'b1, 32'h0000_1400);
        inspect_beats(n0 + 4, 1'b0, 32'h0000_0400);
        report_test("write allocate", err0);
    endtask

    task automatic random_sequence();
        int                 err0;
        logic [31:0]        tag;
        logic [31:0]        idx;
        logic [31:0]        off;
        logic [31:0]        d;
        logic [2:0]         kind;
        logic [FUNCT_W-1:0] f;
        err0 = errors;
        for (int k = 0; k < 40; k++) begin
            tag  = rand_bits(2) % 3;
            idx  = rand_bits(1) ? 32'h23 : 32'h40;
            kind = rand_bits(3);
            off  = rand_bits(4);
            d    = rand_bits(32);
            // Kinds 0 to 4 are loads, 5 to 7 are SB, SH and SW.
            if (kind >= 3'd5) begin
                f = kind - 3'd5;
            end else begin
                f = (kind < 3'd3) ? kind : kind + 3'd1;
            end
            if (f[1:0] == 2'd1) off[0] = 1'b0;
            if (f[1:0] == 2'd2) off[1:0] = 2'b00;
            if (kind >= 3'd5) begin
                store((tag << 11) | (idx << 4) | off, f, d);
            end else begin
                load((tag << 11) | (idx << 4) | off, f);
            end
        end
        report_test("random sequence", err0);
    endtask

    initial begin
        int unsigned limit_ns;
        // Every request taken as a dirty miss with the slowest beats, plus reset.
        limit_ns = 62 * (2 * BEATS * 5 + 6) * 8 + 200;
        #(limit_ns);
        $display("watchdog expired after %0d ns, the tests did not finish", limit_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst          = 1'b0;
        req          = 1'b0;
        we           = 1'b0;
        addr         = '0;
        wdata        = '0;
        funct        = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        last_lat     = 0;
        lfsr         = 16'd49432;
        fill_shadow();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        cold_miss();
        load_hits();
        store_hits();
        dirty_eviction();
        write_allocate();
        random_sequence();

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
rtl/dcache_pkg.sv
rtl/dcache_ctrl.sv
rtl/dcache_line_ram.sv
rtl/dcache_load_align.sv
rtl/dcache_store_merge.sv
rtl/dcache_wb_master.sv
rtl/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - rtl/dcache_pkg.sv
  - rtl/dcache_ctrl.sv
  - rtl/dcache_line_ram.sv
  - rtl/dcache_load_align.sv
  - rtl/dcache_store_merge.sv
  - rtl/dcache_wb_master.sv
  - rtl/dcache_top.sv
  - target: test
    files:
      - testbench/tb_mem_model.sv
      - testbench/tb_dcache.sv
